/* hw/dma_bus_pkg.sv */
// Types of the memory-side read and write channels
// Addresses, beats, counters and the engine state enums

`default_nettype none

package dma_bus_pkg;

    typedef logic [31:0] mem_addr_t;
    typedef logic [63:0] mem_data_t;
    typedef logic [31:0] byte_cnt_t;
    typedef logic [4:0]  beat_cnt_t;
    typedef logic [4:0]  fifo_lvl_t;

    // Burst read request, held until ready
    typedef struct packed {
        logic      valid;
        mem_addr_t addr;
        beat_cnt_t beats;
    } rd_req_t;

    typedef struct packed {
        logic      valid;
        mem_data_t data;
    } rd_resp_t;

    // One write beat, held until ready
    typedef struct packed {
        logic      valid;
        mem_addr_t addr;
        mem_data_t data;
    } wr_req_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_DATA
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_POP,
        WR_SEND,
        WR_ACK
    } wr_state_e;

endpackage

`default_nettype wire

/* hw/dma_consts.svh */
// Register map, control bit positions and sizing constants of the DMA engine

`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// Register byte offsets
`define DMA_REG_SRC     8'h00
`define DMA_REG_DST     8'h08
`define DMA_REG_VOLUME  8'h10
`define DMA_REG_BURST   8'h18
`define DMA_REG_CTRL    8'h1C

// Bit positions in the control/status word
`define DMA_CTRL_START  0
`define DMA_CTRL_DONE   1
`define DMA_CTRL_BUSY   2

// One beat is a 64-bit word
`define DMA_BEAT_BYTES  8

// Data FIFO entries
`define DMA_FIFO_DEPTH  16

// Longest burst in beats
`define DMA_MAX_BURST   16

`endif

/* hw/dma_csr.sv */
// Register block of the DMA engine
// Transfer setup registers, control/status bits and the start pulse

`default_nettype none

`include "dma_consts.svh"

module dma_csr
    import dma_reg_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  reg_req_t  reg_req_i,
    output reg_data_t reg_rdata_o,
    output logic      reg_rvalid_o,
    input  logic      done_i,
    output dma_cfg_t  cfg_o,
    output logic      start_o
);

    reg_data_t  src_q;
    reg_data_t  dst_q;
    reg_data_t  volume_q;
    burst_len_t burst_q;
    logic       start_bit_q;
    logic       done_bit_q;
    logic       busy_bit_q;
    logic       start_pulse_q;
    reg_data_t  ctrl_word;
    reg_data_t  rdata_d;
    reg_data_t  rdata_q;
    logic       rvalid_q;
    logic       wr_en;
    logic       rd_en;
    logic       start_req;

    assign wr_en = reg_req_i.strobe && reg_req_i.we;
    assign rd_en = reg_req_i.strobe && !reg_req_i.we;

    // Start is ignored while a transfer runs
    assign start_req = wr_en && (reg_req_i.addr == `DMA_REG_CTRL)
                     && reg_req_i.wdata[`DMA_CTRL_START] && !busy_bit_q;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[`DMA_CTRL_START] = start_bit_q;
        ctrl_word[`DMA_CTRL_DONE]  = done_bit_q;
        ctrl_word[`DMA_CTRL_BUSY]  = busy_bit_q;
    end

    // ========================================
    // Setup registers
    // ========================================
    // Frozen while busy, the engines read them during the run
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            src_q    <= '0;
            dst_q    <= '0;
            volume_q <= '0;
            burst_q  <= '0;
        end else if (wr_en && !busy_bit_q) begin
            case (reg_req_i.addr)
                `DMA_REG_SRC:    src_q    <= reg_req_i.wdata;
                `DMA_REG_DST:    dst_q    <= reg_req_i.wdata;
                `DMA_REG_VOLUME: volume_q <= reg_req_i.wdata;
                `DMA_REG_BURST:  burst_q  <= reg_req_i.wdata[7:0];
                default: ;
            endcase
        end
    end

    // ========================================
    // Control and status
    // ========================================
    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            start_bit_q   <= 1'b0;
            done_bit_q    <= 1'b0;
            busy_bit_q    <= 1'b0;
            start_pulse_q <= 1'b0;
        end else begin
            start_pulse_q <= start_req;
            if (start_req) begin
                start_bit_q <= 1'b1;
                busy_bit_q  <= 1'b1;
                done_bit_q  <= 1'b0;
            end else if (done_i) begin
                start_bit_q <= 1'b0;
                busy_bit_q  <= 1'b0;
                done_bit_q  <= 1'b1;
            end
        end
    end

    // Readback mux
    always_comb begin
        case (reg_req_i.addr)
            `DMA_REG_SRC:    rdata_d = src_q;
            `DMA_REG_DST:    rdata_d = dst_q;
            `DMA_REG_VOLUME: rdata_d = volume_q;
            `DMA_REG_BURST:  rdata_d = reg_data_t'(burst_q);
            `DMA_REG_CTRL:   rdata_d = ctrl_word;
            default:         rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rdata_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_en;
        end
    end

    assign reg_rdata_o  = rdata_q;
    assign reg_rvalid_o = rvalid_q;
    assign start_o      = start_pulse_q;
    assign cfg_o        = '{src_addr: src_q, dst_addr: dst_q, volume: volume_q,
                            burst_len: burst_q};

    // The write engine finishes a run long after its start, never in the same cycle
    assert property (@(posedge clk_i) disable iff (!rst_i) !(done_i && start_o))
        else $error("dma_csr: start and done pulse together");

endmodule

`default_nettype wire

/* hw/dma_fifo.sv */
// Data FIFO between the read and write engines
// Circular buffer with a fill level and show-ahead output

`default_nettype none

`include "dma_consts.svh"

module dma_fifo
    import dma_bus_pkg::*;
#(
    parameter int DEPTH = `DMA_FIFO_DEPTH
)(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      push_i,
    input  logic      pop_i,
    input  mem_data_t data_i,
    output mem_data_t data_o,
    output logic      full_o,
    output logic      empty_o,
    output fifo_lvl_t lvl_o
);

    localparam int PTR_W = $clog2(DEPTH);

    mem_data_t        mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    fifo_lvl_t        lvl_q;
    logic             do_push;
    logic             do_pop;

    // Wraps at DEPTH, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (lvl_q == fifo_lvl_t'(DEPTH));
    assign empty_o = (lvl_q == '0);
    assign lvl_o   = lvl_q;
    assign data_o  = mem_q[rd_ptr_q];
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            lvl_q    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   lvl_q <= lvl_q + 5'd1;
                2'b01:   lvl_q <= lvl_q - 5'd1;
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_i) !(pop_i && empty_o))
        else $error("dma_fifo: pop while empty");

endmodule

`default_nettype wire

/* hw/dma_read_engine.sv */
// Read side of the DMA engine
// Issues burst reads from the source and pushes returned beats into the FIFO

`default_nettype none

`include "dma_consts.svh"

module dma_read_engine
    import dma_reg_pkg::*;
    import dma_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      start_i,
    input  dma_cfg_t  cfg_i,
    output rd_req_t   rd_req_o,
    input  logic      rd_ready_i,
    input  rd_resp_t  rd_resp_i,
    output logic      rd_resp_ready_o,
    output logic      fifo_push_o,
    output mem_data_t fifo_data_o,
    input  logic      fifo_full_i,
    input  fifo_lvl_t fifo_lvl_i
);

    rd_state_e  state_q;
    rd_state_e  state_d;
    mem_addr_t  addr_q;
    mem_addr_t  addr_d;
    byte_cnt_t  bytes_q;
    byte_cnt_t  bytes_d;
    beat_cnt_t  beats_q;
    beat_cnt_t  beats_d;
    beat_cnt_t  burst_beats;
    logic [5:0] lvl_after;
    logic       has_room;
    logic       req_fire;
    logic       beat_fire;

    assign burst_beats = cfg_i.burst_len[4:0];

    // Only ask for a burst the FIFO can take in full
    assign lvl_after = {1'b0, fifo_lvl_i} + {1'b0, burst_beats};
    assign has_room  = (lvl_after <= 6'(`DMA_FIFO_DEPTH));

    assign rd_req_o.valid  = (state_q == RD_REQ) && has_room;
    assign rd_req_o.addr   = addr_q;
    assign rd_req_o.beats  = burst_beats;
    assign rd_resp_ready_o = (state_q == RD_DATA) && !fifo_full_i;

    assign req_fire    = rd_req_o.valid && rd_ready_i;
    assign beat_fire   = rd_resp_i.valid && rd_resp_ready_o;
    assign fifo_push_o = beat_fire;
    assign fifo_data_o = rd_resp_i.data;

    // ========================================
    // Burst FSM
    // ========================================
    always_comb begin
        state_d = state_q;
        addr_d  = addr_q;
        bytes_d = bytes_q;
        beats_d = beats_q;
        case (state_q)
            RD_IDLE: begin
                if (start_i) begin
                    addr_d  = cfg_i.src_addr;
                    bytes_d = cfg_i.volume;
                    state_d = RD_REQ;
                end
            end
            RD_REQ: begin
                if (req_fire) begin
                    beats_d = burst_beats;
                    state_d = RD_DATA;
                end
            end
            RD_DATA: begin
                if (beat_fire) begin
                    addr_d  = addr_q + mem_addr_t'(`DMA_BEAT_BYTES);
                    bytes_d = bytes_q - byte_cnt_t'(`DMA_BEAT_BYTES);
                    beats_d = beats_q - 5'd1;
                    // Last beat of the burst, and maybe of the whole run
                    if (beats_q == 5'd1) begin
                        if (bytes_q == byte_cnt_t'(`DMA_BEAT_BYTES)) begin
                            state_d = RD_IDLE;
                        end else begin
                            state_d = RD_REQ;
                        end
                    end
                end
            end
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            state_q <= RD_IDLE;
            addr_q  <= '0;
            bytes_q <= '0;
            beats_q <= '0;
        end else begin
            state_q <= state_d;
            addr_q  <= addr_d;
            bytes_q <= bytes_d;
            beats_q <= beats_d;
        end
    end

    // Room reserved per burst keeps the FIFO from filling up mid-burst
    assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_q == RD_DATA) |-> !fifo_full_i)
        else $error("dma_read_engine: FIFO full during a burst");

    // Burst length from software must fit the reservation
    assert property (@(posedge clk_i) disable iff (!rst_i)
        start_i |-> (cfg_i.burst_len != '0) && (cfg_i.burst_len <= 8'(`DMA_MAX_BURST)))
        else $error("dma_read_engine: burst length out of range");

endmodule

`default_nettype wire

/* hw/dma_reg_pkg.sv */
// Types of the software register port
// Register words, request strobe and the transfer setup seen by the engines

`default_nettype none

package dma_reg_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [7:0]  burst_len_t;

    // Single-cycle access from software
    typedef struct packed {
        logic      strobe;
        logic      we;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    // Transfer setup handed to both engines
    typedef struct packed {
        reg_data_t  src_addr;
        reg_data_t  dst_addr;
        reg_data_t  volume;
        burst_len_t burst_len;
    } dma_cfg_t;

endpackage

`default_nettype wire

/* hw/dma_top.sv */
// Top level of the memory-to-memory DMA engine
// Register block, read engine, data FIFO and write engine

`default_nettype none

module dma_top
    import dma_reg_pkg::*;
    import dma_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  reg_req_t  reg_req_i,
    output reg_data_t reg_rdata_o,
    output logic      reg_rvalid_o,
    output rd_req_t   mem_rd_req_o,
    input  logic      mem_rd_ready_i,
    input  rd_resp_t  mem_rd_resp_i,
    output logic      mem_rd_resp_ready_o,
    output wr_req_t   mem_wr_req_o,
    input  logic      mem_wr_ready_i,
    input  logic      mem_wr_ack_i,
    output logic      mem_wr_ack_ready_o
);

    dma_cfg_t  cfg;
    logic      start;
    logic      done;
    logic      fifo_push;
    logic      fifo_pop;
    mem_data_t fifo_wdata;
    mem_data_t fifo_rdata;
    logic      fifo_full;
    logic      fifo_empty;
    fifo_lvl_t fifo_lvl;

    dma_csr u_csr (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .reg_req_i    (reg_req_i),
        .reg_rdata_o  (reg_rdata_o),
        .reg_rvalid_o (reg_rvalid_o),
        .done_i       (done),
        .cfg_o        (cfg),
        .start_o      (start)
    );

    dma_read_engine u_rd (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .start_i         (start),
        .cfg_i           (cfg),
        .rd_req_o        (mem_rd_req_o),
        .rd_ready_i      (mem_rd_ready_i),
        .rd_resp_i       (mem_rd_resp_i),
        .rd_resp_ready_o (mem_rd_resp_ready_o),
        .fifo_push_o     (fifo_push),
        .fifo_data_o     (fifo_wdata),
        .fifo_full_i     (fifo_full),
        .fifo_lvl_i      (fifo_lvl)
    );

    dma_fifo u_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (fifo_push),
        .pop_i   (fifo_pop),
        .data_i  (fifo_wdata),
        .data_o  (fifo_rdata),
        .full_o  (fifo_full),
        .empty_o (fifo_empty),
        .lvl_o   (fifo_lvl)
    );

    dma_write_engine u_wr (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (start),
        .cfg_i          (cfg),
        .fifo_pop_o     (fifo_pop),
        .fifo_data_i    (fifo_rdata),
        .fifo_empty_i   (fifo_empty),
        .wr_req_o       (mem_wr_req_o),
        .wr_ready_i     (mem_wr_ready_i),
        .wr_ack_i       (mem_wr_ack_i),
        .wr_ack_ready_o (mem_wr_ack_ready_o),
        .done_o         (done)
    );

endmodule

`default_nettype wire

/* hw/dma_write_engine.sv */
// Write side of the DMA engine
// Drains the FIFO into destination bursts, waits for each burst ack, flags done

`default_nettype none

`include "dma_consts.svh"

module dma_write_engine
    import dma_reg_pkg::*;
    import dma_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      start_i,
    input  dma_cfg_t  cfg_i,
    output logic      fifo_pop_o,
    input  mem_data_t fifo_data_i,
    input  logic      fifo_empty_i,
    output wr_req_t   wr_req_o,
    input  logic      wr_ready_i,
    input  logic      wr_ack_i,
    output logic      wr_ack_ready_o,
    output logic      done_o
);

    wr_state_e state_q;
    wr_state_e state_d;
    mem_addr_t addr_q;
    mem_addr_t addr_d;
    byte_cnt_t bytes_q;
    byte_cnt_t bytes_d;
    beat_cnt_t beats_q;
    beat_cnt_t beats_d;
    beat_cnt_t burst_beats;
    mem_data_t data_q;

    assign burst_beats = cfg_i.burst_len[4:0];

    assign fifo_pop_o     = (state_q == WR_POP) && !fifo_empty_i;
    assign wr_req_o.valid = (state_q == WR_SEND);
    assign wr_req_o.addr  = addr_q;
    assign wr_req_o.data  = data_q;
    assign wr_ack_ready_o = (state_q == WR_ACK);

    // Ack of the final burst ends the run
    assign done_o = wr_ack_ready_o && wr_ack_i && (bytes_q == '0);

    // Beat held here until the write channel takes it
    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            data_q <= fifo_data_i;
        end
    end

    // ========================================
    // Burst FSM
    // ========================================
    always_comb begin
        state_d = state_q;
        addr_d  = addr_q;
        bytes_d = bytes_q;
        beats_d = beats_q;
        case (state_q)
            WR_IDLE: begin
                if (start_i) begin
                    addr_d  = cfg_i.dst_addr;
                    bytes_d = cfg_i.volume;
                    beats_d = burst_beats;
                    state_d = WR_POP;
                end
            end
            WR_POP: begin
                if (fifo_pop_o) begin
                    state_d = WR_SEND;
                end
            end
            WR_SEND: begin
                if (wr_ready_i) begin
                    addr_d  = addr_q + mem_addr_t'(`DMA_BEAT_BYTES);
                    bytes_d = bytes_q - byte_cnt_t'(`DMA_BEAT_BYTES);
                    beats_d = beats_q - 5'd1;
                    state_d = (beats_q == 5'd1) ? WR_ACK : WR_POP;
                end
            end
            WR_ACK: begin
                if (wr_ack_i) begin
                    beats_d = burst_beats;
                    state_d = (bytes_q == '0) ? WR_IDLE : WR_POP;
                end
            end
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_i) begin
        if (!rst_i) begin
            state_q <= WR_IDLE;
            addr_q  <= '0;
            bytes_q <= '0;
            beats_q <= '0;
        end else begin
            state_q <= state_d;
            addr_q  <= addr_d;
            bytes_q <= bytes_d;
            beats_q <= beats_d;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/dma_reg_pkg.sv
hw/dma_bus_pkg.sv
hw/dma_csr.sv
hw/dma_read_engine.sv
hw/dma_fifo.sv
hw/dma_write_engine.sv
hw/dma_top.sv
tests/tb_dma.sv

/* tests/tb_dma.sv */
// Directed testbench of the DMA engine
// Memory model with random delays, register driver, compare tasks, timeout

`default_nettype none

`include "dma_consts.svh"

module tb_dma
    import dma_reg_pkg::*;
    import dma_bus_pkg::*;
();

    localparam int TOTAL_BEATS = 4 + 32 + 16 + 16;
    localparam int CYCLE_LIMIT = TOTAL_BEATS * 40 + 1000;

    localparam reg_data_t START_WORD   = reg_data_t'(1) << `DMA_CTRL_START;
    localparam reg_data_t DONE_WORD    = reg_data_t'(1) << `DMA_CTRL_DONE;
    localparam reg_data_t RUNNING_WORD = (reg_data_t'(1) << `DMA_CTRL_START)
                                       | (reg_data_t'(1) << `DMA_CTRL_BUSY);

    logic      clk;
    logic      rst_i;
    reg_req_t  reg_req;
    reg_data_t reg_rdata_o;
    logic      reg_rvalid_o;
    rd_req_t   mem_rd_req_o;
    logic      mem_rd_ready;
    rd_resp_t  mem_rd_resp;
    logic      mem_rd_resp_ready_o;
    wr_req_t   mem_wr_req_o;
    logic      mem_wr_ready;
    logic      mem_wr_ack;
    logic      mem_wr_ack_ready_o;

    // 4 KB memory indexed by beat
    mem_data_t mem [512];

    // Expected destination writes in order
    mem_addr_t exp_addr_q [$];
    mem_data_t exp_data_q [$];

    int          errors;
    int          checks;
    int          cycles;
    logic        stall_en;
    int          burst_len;
    int          exp_bursts;
    mem_addr_t   rd_exp_addr;
    mem_addr_t   rd_addr;
    int          rd_left;
    int          rd_gap;
    int          rd_req_cnt;
    int          wr_in_burst;
    int          ack_gap;
    int          ack_cnt;

    dma_top dut_i (
        .clk_i               (clk),
        .rst_i               (rst_i),
        .reg_req_i           (reg_req),
        .reg_rdata_o         (reg_rdata_o),
        .reg_rvalid_o        (reg_rvalid_o),
        .mem_rd_req_o        (mem_rd_req_o),
        .mem_rd_ready_i      (mem_rd_ready),
        .mem_rd_resp_i       (mem_rd_resp),
        .mem_rd_resp_ready_o (mem_rd_resp_ready_o),
        .mem_wr_req_o        (mem_wr_req_o),
        .mem_wr_ready_i      (mem_wr_ready),
        .mem_wr_ack_i        (mem_wr_ack),
        .mem_wr_ack_ready_o  (mem_wr_ack_ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_beat(input mem_addr_t addr, input mem_data_t got,
                              input mem_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: mem_wr_req_o.data at %h got %h expected %h",
                     $time, addr, got, exp);
        end
    endtask

    // ========================================
    // Memory model
    // ========================================
    function automatic logic pick_stall();
        return stall_en && ($urandom_range(3) == 0);
    endfunction

    function automatic int pick_delay(input int max_gap);
        if (!stall_en) begin
            return 0;
        end
        return int'($urandom_range(max_gap));
    endfunction

    // DUT valids and readies do not depend on these inputs, so the
    // handshake for the next rising edge is known here
    task automatic serve_read_beats();
        mem_rd_resp.valid = 1'b0;
        if (rd_left != 0) begin
            if (rd_gap != 0) begin
                rd_gap--;
            end else begin
                mem_rd_resp.valid = 1'b1;
                mem_rd_resp.data  = mem[rd_addr[11:3]];
                if (mem_rd_resp_ready_o) begin
                    rd_addr = rd_addr + `DMA_BEAT_BYTES;
                    rd_left--;
                    rd_gap = pick_delay(3);
                end
            end
        end
    endtask

    task automatic accept_read_request();
        mem_rd_ready = 1'b0;
        if (mem_rd_req_o.valid && rd_left == 0 && !pick_stall()) begin
            mem_rd_ready = 1'b1;
            check_addr("mem_rd_req_o.addr", mem_rd_req_o.addr, rd_exp_addr);
            check_reg("mem_rd_req_o.beats", reg_data_t'(mem_rd_req_o.beats),
                      reg_data_t'(burst_len));
            rd_exp_addr = rd_exp_addr + burst_len * `DMA_BEAT_BYTES;
            rd_addr     = mem_rd_req_o.addr;
            rd_left     = burst_len;
            rd_gap      = pick_delay(3);
            rd_req_cnt++;
        end
    endtask

    task automatic accept_write_beat();
        mem_addr_t ea;
        mem_data_t ed;
        mem_wr_ready = 1'b0;
        if (mem_wr_req_o.valid && !pick_stall()) begin
            mem_wr_ready = 1'b1;
            if (exp_addr_q.size() == 0) begin
                errors++;
                $display("Error at %0t: write to %h beyond the programmed volume",
                         $time, mem_wr_req_o.addr);
            end else begin
                ea = exp_addr_q.pop_front();
                ed = exp_data_q.pop_front();
                check_addr("mem_wr_req_o.addr", mem_wr_req_o.addr, ea);
                check_beat(ea, mem_wr_req_o.data, ed);
            end
            mem[mem_wr_req_o.addr[11:3]] = mem_wr_req_o.data;
            wr_in_burst++;
        end
    endtask

    task automatic answer_write_ack();
        mem_wr_ack = 1'b0;
        if (mem_wr_ack_ready_o) begin
            if (ack_gap != 0) begin
                ack_gap--;
            end else begin
                mem_wr_ack = 1'b1;
                // One ack wait per complete burst
                check_reg("beats before ack", reg_data_t'(wr_in_burst),
                          reg_data_t'(burst_len));
                wr_in_burst = 0;
                ack_cnt++;
                ack_gap = pick_delay(2);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_i) begin
            serve_read_beats();
            accept_read_request();
            accept_write_beat();
            answer_write_ack();
        end
    end

    // ========================================
    // Register driver and transfer helpers
    // ========================================
    task automatic write_reg(input reg_addr_t offset, input reg_data_t data);
        @(negedge clk);
        reg_req.strobe = 1'b1;
        reg_req.we     = 1'b1;
        reg_req.addr   = offset;
        reg_req.wdata  = data;
        @(negedge clk);
        reg_req = '0;
    endtask

    task automatic read_reg(input reg_addr_t offset, output reg_data_t data);
        @(negedge clk);
        reg_req.strobe = 1'b1;
        reg_req.we     = 1'b0;
        reg_req.addr   = offset;
        reg_req.wdata  = '0;
        @(negedge clk);
        reg_req = '0;
        if (!reg_rvalid_o) begin
            errors++;
            $display("Error at %0t: no read valid one cycle after reading offset %h",
                     $time, offset);
        end
        data = reg_rdata_o;
    endtask

    task automatic setup_transfer(input mem_addr_t src, input mem_addr_t dst,
                                  input byte_cnt_t volume, input int burst,
                                  input logic stalls);
        int        beats;
        int        k;
        mem_addr_t sa;
        beats = volume / `DMA_BEAT_BYTES;
        exp_addr_q.delete();
        exp_data_q.delete();
        // Destination beat k is source beat k
        for (k = 0; k < beats; k++) begin
            sa = src + k * `DMA_BEAT_BYTES;
            exp_addr_q.push_back(dst + k * `DMA_BEAT_BYTES);
            exp_data_q.push_back(mem[sa[11:3]]);
        end
        burst_len   = burst;
        exp_bursts  = beats / burst;
        stall_en    = stalls;
        rd_exp_addr = src;
        rd_req_cnt  = 0;
        ack_cnt     = 0;
        wr_in_burst = 0;
        ack_gap     = 0;
        write_reg(`DMA_REG_SRC, src);
        write_reg(`DMA_REG_DST, dst);
        write_reg(`DMA_REG_VOLUME, volume);
        write_reg(`DMA_REG_BURST, reg_data_t'(burst));
    endtask

    task automatic wait_done();
        reg_data_t ctrl;
        ctrl = '0;
        while (!ctrl[`DMA_CTRL_DONE]) begin
            read_reg(`DMA_REG_CTRL, ctrl);
        end
    endtask

    task automatic check_transfer_end();
        reg_data_t ctrl;
        if (exp_addr_q.size() != 0) begin
            errors++;
            $display("Error at %0t: %0d destination beats were never written",
                     $time, exp_addr_q.size());
        end
        check_reg("read bursts", reg_data_t'(rd_req_cnt), reg_data_t'(exp_bursts));
        check_reg("write acks", reg_data_t'(ack_cnt), reg_data_t'(exp_bursts));
        read_reg(`DMA_REG_CTRL, ctrl);
        check_reg("ctrl", ctrl, DONE_WORD);
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_reg_readback();
        reg_data_t v;
        read_reg(`DMA_REG_CTRL, v);
        check_reg("ctrl after reset", v, '0);
        write_reg(`DMA_REG_SRC, 32'h1234_5678);
        write_reg(`DMA_REG_DST, 32'h9abc_def0);
        write_reg(`DMA_REG_VOLUME, 32'h0000_0400);
        write_reg(`DMA_REG_BURST, 32'h0000_0010);
        read_reg(`DMA_REG_SRC, v);
        check_reg("src", v, 32'h1234_5678);
        read_reg(`DMA_REG_DST, v);
        check_reg("dst", v, 32'h9abc_def0);
        read_reg(`DMA_REG_VOLUME, v);
        check_reg("volume", v, 32'h0000_0400);
        read_reg(`DMA_REG_BURST, v);
        check_reg("burst", v, 32'h0000_0010);
    endtask

    task automatic test_single_burst();
        setup_transfer(32'h0000_0040, 32'h0000_0800, 32, 4, 1'b0);
        write_reg(`DMA_REG_CTRL, START_WORD);
        wait_done();
        check_transfer_end();
    endtask

    task automatic test_multi_burst();
        setup_transfer(32'h0000_0100, 32'h0000_0900, 256, 8, 1'b1);
        write_reg(`DMA_REG_CTRL, START_WORD);
        wait_done();
        check_transfer_end();
    endtask

    task automatic test_busy_restart();
        reg_data_t v;
        setup_transfer(32'h0000_0300, 32'h0000_0a00, 128, 4, 1'b1);
        write_reg(`DMA_REG_CTRL, START_WORD);
        read_reg(`DMA_REG_CTRL, v);
        check_reg("ctrl while running", v, RUNNING_WORD);
        // Second start once the reads are over and the writes still drain
        while (rd_req_cnt < exp_bursts || rd_left != 0) begin
            @(posedge clk);
        end
        write_reg(`DMA_REG_CTRL, START_WORD);
        wait_done();
        check_transfer_end();
    endtask

    task automatic test_back_to_back();
        reg_data_t v;
        read_reg(`DMA_REG_CTRL, v);
        check_reg("ctrl before restart", v, DONE_WORD);
        setup_transfer(32'h0000_0380, 32'h0000_0c00, 128, 2, 1'b1);
        write_reg(`DMA_REG_CTRL, START_WORD);
        read_reg(`DMA_REG_CTRL, v);
        check_reg("ctrl after restart", v, RUNNING_WORD);
        wait_done();
        check_transfer_end();
    endtask

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DMA never reported done", cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(32'h83f8ae50));
        errors       = 0;
        checks       = 0;
        stall_en     = 1'b0;
        burst_len    = 1;
        exp_bursts   = 0;
        rd_exp_addr  = '0;
        rd_addr      = '0;
        rd_left      = 0;
        rd_gap       = 0;
        rd_req_cnt   = 0;
        wr_in_burst  = 0;
        ack_gap      = 0;
        ack_cnt      = 0;
        rst_i        = 1'b0;
        reg_req      = '0;
        mem_rd_ready = 1'b0;
        mem_rd_resp  = '0;
        mem_wr_ready = 1'b0;
        mem_wr_ack   = 1'b0;
        for (int i = 0; i < 512; i++) begin
            mem[i] = {$urandom, $urandom};
        end

        repeat (10) @(negedge clk);
        rst_i = 1'b1;

        test_reg_readback();
        test_single_burst();
        test_multi_burst();
        test_busy_restart();
        test_back_to_back();

        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
